// File: rv_dec_cfg.svh
`ifndef RV_DEC_CFG_SVH
`define RV_DEC_CFG_SVH

`define DEC_LANES 2
`define XLEN 32

// index of the trapping lane, one bit minimum
`define TRAP_LANE_W ((`DEC_LANES > 1) ? $clog2(`DEC_LANES) : 1)

`endif

// File: rv_dec_pkg.sv
package rv_dec_pkg;

  // rv32i major opcodes handled by the stage
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_R      = 7'b0110011,
    OP_I      = 7'b0010011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
  } mem_op_t;

  typedef enum logic [1:0] {CF_NONE, CF_BRANCH, CF_JUMP, CF_JALR} cf_op_t;

  typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

  typedef enum logic [2:0] {
    IMM_I_ALU, IMM_I_SHIFT, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR
  } imm_ext_op_t;

  // compare codes double as branch conditions
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_XOR, ALU_OR, ALU_AND
  } alu_ctrl_t;

  typedef enum logic [1:0] {ALU_A_REG, ALU_A_PC, ALU_A_ZERO} alu_a_sel_t;

  typedef enum logic {ALU_B_REG, ALU_B_IMM} alu_b_sel_t;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_NEXT_PC, RES_CSR} result_sel_t;

  // mcause exception codes, interrupt bit kept elsewhere
  typedef enum logic [30:0] {
    TRAP_ILLEGAL    = 31'd2,
    TRAP_BREAKPOINT = 31'd3,
    TRAP_ECALL_M    = 31'd11
  } trap_code_t;

endpackage

// File: fetch_bundle_split.sv
`timescale 1ns/1ns
`include "rv_dec_cfg.svh"

module fetch_bundle_split (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            in_valid,
  input  logic [`DEC_LANES*`XLEN-1:0]     in_instr,
  input  logic [`DEC_LANES-1:0]           in_lane_mask,
  output logic [`XLEN-1:0]                lane_instr [`DEC_LANES],
  output logic [`DEC_LANES-1:0]           lane_valid
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_valid <= '0;
    end else begin
      lane_valid <= in_valid ? in_lane_mask : '0;  // strobe, no hold
    end
  end

  // lane 0 takes the low word
  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int i = 0; i < `DEC_LANES; i++) begin
        lane_instr[i] <= in_instr[i*`XLEN +: `XLEN];
      end
    end
  end

  // an x strobe or mask would leak into the issue scan
  a_lane_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(lane_valid));

endmodule

// File: decoder.sv
`timescale 1ns/1ns
`include "rv_dec_cfg.svh"

module decoder (
  input  logic [`XLEN-1:0]        instr,
  output logic                    rd_valid,
  output logic                    rs1_valid,
  output logic                    rs2_valid,
  output rv_dec_pkg::mem_op_t     mem_op,
  output rv_dec_pkg::cf_op_t      cf_op,
  output rv_dec_pkg::csr_op_t     csr_op,
  output rv_dec_pkg::alu_ctrl_t   alu_control,
  output rv_dec_pkg::imm_ext_op_t imm_kind,
  output rv_dec_pkg::alu_a_sel_t  alu_a_src,
  output rv_dec_pkg::alu_b_sel_t  alu_b_src,
  output logic                    pc_alu_src,
  output rv_dec_pkg::result_sel_t result_src,
  output logic                    csr_bitmask_sel,
  output logic                    trap_valid,
  output rv_dec_pkg::trap_code_t  trap_mcause
);

  rv_dec_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [11:0]         funct12;
  logic [4:0]          rs1;
  logic [4:0]          rd;
  logic                alt;
  logic                shift_f3;
  logic                bad_r_funct7;
  logic                bad_shift_funct7;

  assign opcode   = rv_dec_pkg::opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];
  assign funct12  = instr[31:20];
  assign rs1      = instr[19:15];
  assign rd       = instr[11:7];
  assign alt      = instr[30];  // sub / sra / srai
  assign shift_f3 = (funct3 == 3'b001) || (funct3 == 3'b101);

  // only add/sub and srl/sra have a second funct7 encoding
  assign bad_r_funct7 = (funct7 != 7'h00) &&
                        !((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
  assign bad_shift_funct7 = shift_f3 && (funct7 != 7'h00) &&
                            !((funct3 == 3'b101) && (funct7 == 7'h20));

  function automatic rv_dec_pkg::alu_ctrl_t arith_ctrl(input logic [2:0] f3,
                                                       input logic       sub_sel,
                                                       input logic       sra_sel);
    case (f3)
      3'b000: begin
        if (sub_sel) return rv_dec_pkg::ALU_SUB;
        return rv_dec_pkg::ALU_ADD;
      end
      3'b001: return rv_dec_pkg::ALU_SLL;
      3'b010: return rv_dec_pkg::ALU_LT;
      3'b011: return rv_dec_pkg::ALU_LTU;
      3'b100: return rv_dec_pkg::ALU_XOR;
      3'b101: begin
        if (sra_sel) return rv_dec_pkg::ALU_SRA;
        return rv_dec_pkg::ALU_SRL;
      end
      3'b110: return rv_dec_pkg::ALU_OR;
      default: return rv_dec_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    rd_valid        = 1'b0;
    rs1_valid       = 1'b0;
    rs2_valid       = 1'b0;
    mem_op          = rv_dec_pkg::MEM_NONE;
    cf_op           = rv_dec_pkg::CF_NONE;
    csr_op          = rv_dec_pkg::CSR_NONE;
    alu_control     = rv_dec_pkg::ALU_ADD;  // addresses, lui, auipc
    imm_kind        = rv_dec_pkg::IMM_I_ALU;
    alu_a_src       = rv_dec_pkg::ALU_A_REG;
    alu_b_src       = rv_dec_pkg::ALU_B_REG;
    pc_alu_src      = 1'b0;
    result_src      = rv_dec_pkg::RES_ALU;
    csr_bitmask_sel = 1'b0;
    trap_valid      = 1'b0;
    trap_mcause     = rv_dec_pkg::TRAP_ILLEGAL;

    case (opcode)
      rv_dec_pkg::OP_LOAD: begin
        rd_valid   = 1'b1;
        rs1_valid  = 1'b1;
        alu_b_src  = rv_dec_pkg::ALU_B_IMM;
        result_src = rv_dec_pkg::RES_MEM;
        case (funct3)
          3'b000:  mem_op = rv_dec_pkg::MEM_LB;
          3'b001:  mem_op = rv_dec_pkg::MEM_LH;
          3'b010:  mem_op = rv_dec_pkg::MEM_LW;
          3'b100:  mem_op = rv_dec_pkg::MEM_LBU;
          3'b101:  mem_op = rv_dec_pkg::MEM_LHU;
          default: trap_valid = 1'b1;
        endcase
      end
      rv_dec_pkg::OP_STORE: begin
        rs1_valid = 1'b1;
        rs2_valid = 1'b1;
        imm_kind  = rv_dec_pkg::IMM_S;
        alu_b_src = rv_dec_pkg::ALU_B_IMM;
        case (funct3)
          3'b000:  mem_op = rv_dec_pkg::MEM_SB;
          3'b001:  mem_op = rv_dec_pkg::MEM_SH;
          3'b010:  mem_op = rv_dec_pkg::MEM_SW;
          default: trap_valid = 1'b1;
        endcase
      end
      rv_dec_pkg::OP_R: begin
        if (bad_r_funct7) begin
          trap_valid = 1'b1;
        end else begin
          rd_valid    = 1'b1;
          rs1_valid   = 1'b1;
          rs2_valid   = 1'b1;
          alu_control = arith_ctrl(funct3, alt, alt);
        end
      end
      rv_dec_pkg::OP_I: begin
        if (bad_shift_funct7) begin
          trap_valid = 1'b1;
        end else begin
          rd_valid    = 1'b1;
          rs1_valid   = 1'b1;
          alu_b_src   = rv_dec_pkg::ALU_B_IMM;
          alu_control = arith_ctrl(funct3, 1'b0, alt);  // bit 30 is imm for addi
          if (shift_f3) imm_kind = rv_dec_pkg::IMM_I_SHIFT;
        end
      end
      rv_dec_pkg::OP_BRANCH: begin
        rs1_valid = 1'b1;
        rs2_valid = 1'b1;
        imm_kind  = rv_dec_pkg::IMM_B;
        cf_op     = rv_dec_pkg::CF_BRANCH;
        case (funct3)
          3'b000:  alu_control = rv_dec_pkg::ALU_SUB;  // beq on zero result
          3'b001:  alu_control = rv_dec_pkg::ALU_NE;
          3'b100:  alu_control = rv_dec_pkg::ALU_LT;
          3'b101:  alu_control = rv_dec_pkg::ALU_GE;
          3'b110:  alu_control = rv_dec_pkg::ALU_LTU;
          3'b111:  alu_control = rv_dec_pkg::ALU_GEU;
          default: trap_valid = 1'b1;
        endcase
      end
      rv_dec_pkg::OP_JAL: begin
        rd_valid   = 1'b1;
        imm_kind   = rv_dec_pkg::IMM_J;
        cf_op      = rv_dec_pkg::CF_JUMP;
        result_src = rv_dec_pkg::RES_NEXT_PC;
      end
      rv_dec_pkg::OP_JALR: begin
        rd_valid   = 1'b1;
        rs1_valid  = 1'b1;
        alu_b_src  = rv_dec_pkg::ALU_B_IMM;
        cf_op      = rv_dec_pkg::CF_JALR;
        result_src = rv_dec_pkg::RES_NEXT_PC;
        pc_alu_src = 1'b1;  // target base is rs1, not pc
        if (funct3 != 3'b000) trap_valid = 1'b1;
      end
      rv_dec_pkg::OP_LUI: begin
        rd_valid  = 1'b1;
        imm_kind  = rv_dec_pkg::IMM_U;
        alu_a_src = rv_dec_pkg::ALU_A_ZERO;
        alu_b_src = rv_dec_pkg::ALU_B_IMM;
      end
      rv_dec_pkg::OP_AUIPC: begin
        rd_valid  = 1'b1;
        imm_kind  = rv_dec_pkg::IMM_U;
        alu_a_src = rv_dec_pkg::ALU_A_PC;
        alu_b_src = rv_dec_pkg::ALU_B_IMM;
      end
      rv_dec_pkg::OP_SYSTEM: begin
        case (funct3)
          3'b000: begin
            trap_valid = 1'b1;
            if ((rs1 == 5'd0) && (rd == 5'd0)) begin
              if (funct12 == 12'h000) trap_mcause = rv_dec_pkg::TRAP_ECALL_M;
              else if (funct12 == 12'h001) trap_mcause = rv_dec_pkg::TRAP_BREAKPOINT;
            end
          end
          3'b100: trap_valid = 1'b1;
          default: begin
            // csr forms, bit 2 picks the uimm variant
            rd_valid        = 1'b1;
            rs1_valid       = !funct3[2];
            result_src      = rv_dec_pkg::RES_CSR;
            csr_bitmask_sel = funct3[2];
            if (funct3[2]) imm_kind = rv_dec_pkg::IMM_CSR;
            case (funct3[1:0])
              2'b01: csr_op = rv_dec_pkg::CSR_WRITE;
              2'b10: if (rs1 != 5'd0) csr_op = rv_dec_pkg::CSR_SET;
              default: if (rs1 != 5'd0) csr_op = rv_dec_pkg::CSR_CLEAR;
            endcase
          end
        endcase
      end
      default: trap_valid = 1'b1;
    endcase
  end

endmodule

// File: imm_extender.sv
`timescale 1ns/1ns
`include "rv_dec_cfg.svh"

module imm_extender (
  input  logic [`XLEN-1:0]        instr,
  input  rv_dec_pkg::imm_ext_op_t imm_kind,
  output logic [`XLEN-1:0]        imm
);

  always_comb begin
    case (imm_kind)
      rv_dec_pkg::IMM_I_ALU:   imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
      rv_dec_pkg::IMM_I_SHIFT: imm = {{(`XLEN-5){1'b0}}, instr[24:20]};  // shamt only
      rv_dec_pkg::IMM_S:       imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
      rv_dec_pkg::IMM_B: begin
        imm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rv_dec_pkg::IMM_U:       imm = {instr[31:12], {(`XLEN-20){1'b0}}};
      rv_dec_pkg::IMM_J: begin
        imm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      rv_dec_pkg::IMM_CSR:     imm = {{(`XLEN-5){1'b0}}, instr[19:15]};  // uimm in rs1 field
      default:                 imm = '0;
    endcase
  end

endmodule

// File: issue_collector.sv
`timescale 1ns/1ns
`include "rv_dec_cfg.svh"

module issue_collector (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [`DEC_LANES-1:0]         lane_valid,
  input  logic [`DEC_LANES-1:0]         dec_rd_valid,
  input  logic [`DEC_LANES-1:0]         dec_rs1_valid,
  input  logic [`DEC_LANES-1:0]         dec_rs2_valid,
  input  rv_dec_pkg::mem_op_t           dec_mem_op [`DEC_LANES],
  input  rv_dec_pkg::cf_op_t            dec_cf_op [`DEC_LANES],
  input  rv_dec_pkg::csr_op_t           dec_csr_op [`DEC_LANES],
  input  rv_dec_pkg::alu_ctrl_t         dec_alu_control [`DEC_LANES],
  input  rv_dec_pkg::alu_a_sel_t        dec_alu_a_src [`DEC_LANES],
  input  rv_dec_pkg::alu_b_sel_t        dec_alu_b_src [`DEC_LANES],
  input  rv_dec_pkg::result_sel_t       dec_result_src [`DEC_LANES],
  input  logic [`DEC_LANES-1:0]         dec_csr_bitmask_sel,
  input  logic [`XLEN-1:0]              dec_imm [`DEC_LANES],
  input  logic [`DEC_LANES-1:0]         dec_trap_valid,
  input  rv_dec_pkg::trap_code_t        dec_trap_mcause [`DEC_LANES],
  output logic [`DEC_LANES-1:0]         out_valid,
  output logic [`DEC_LANES-1:0]         out_rd_valid,
  output logic [`DEC_LANES-1:0]         out_rs1_valid,
  output logic [`DEC_LANES-1:0]         out_rs2_valid,
  output rv_dec_pkg::mem_op_t           out_mem_op [`DEC_LANES],
  output rv_dec_pkg::cf_op_t            out_cf_op [`DEC_LANES],
  output rv_dec_pkg::csr_op_t           out_csr_op [`DEC_LANES],
  output rv_dec_pkg::alu_ctrl_t         out_alu_control [`DEC_LANES],
  output rv_dec_pkg::alu_a_sel_t        out_alu_a_src [`DEC_LANES],
  output rv_dec_pkg::alu_b_sel_t        out_alu_b_src [`DEC_LANES],
  output rv_dec_pkg::result_sel_t       out_result_src [`DEC_LANES],
  output logic [`DEC_LANES-1:0]         out_csr_bitmask_sel,
  output logic [`XLEN-1:0]              out_imm [`DEC_LANES],
  output logic                          out_trap_valid,
  output logic [`TRAP_LANE_W-1:0]       out_trap_lane,
  output rv_dec_pkg::trap_code_t        out_trap_mcause
);

  logic [`DEC_LANES-1:0]   issue;
  logic                    trap_hit;
  logic [`TRAP_LANE_W-1:0] trap_lane;
  rv_dec_pkg::trap_code_t  trap_cause;

  // lowest masked-in trap wins, everything above it is dropped
  always_comb begin
    issue      = '0;
    trap_hit   = 1'b0;
    trap_lane  = '0;
    trap_cause = rv_dec_pkg::TRAP_ILLEGAL;
    for (int i = 0; i < `DEC_LANES; i++) begin
      if (lane_valid[i] && !trap_hit) begin
        if (dec_trap_valid[i]) begin
          trap_hit   = 1'b1;
          trap_lane  = i[`TRAP_LANE_W-1:0];
          trap_cause = dec_trap_mcause[i];
        end else begin
          issue[i] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid      <= '0;
      out_trap_valid <= 1'b0;
    end else begin
      out_valid      <= issue;
      out_trap_valid <= trap_hit;
    end
  end

  always_ff @(posedge clk) begin
    out_rd_valid        <= dec_rd_valid;
    out_rs1_valid       <= dec_rs1_valid;
    out_rs2_valid       <= dec_rs2_valid;
    out_mem_op          <= dec_mem_op;
    out_cf_op           <= dec_cf_op;
    out_csr_op          <= dec_csr_op;
    out_alu_control     <= dec_alu_control;
    out_alu_a_src       <= dec_alu_a_src;
    out_alu_b_src       <= dec_alu_b_src;
    out_result_src      <= dec_result_src;
    out_csr_bitmask_sel <= dec_csr_bitmask_sel;
    out_imm             <= dec_imm;
    out_trap_lane       <= trap_lane;
    out_trap_mcause     <= trap_cause;
  end

  a_nothing_past_trap: assert property (@(posedge clk) disable iff (!rst_n)
    out_trap_valid |-> ((out_valid >> out_trap_lane) == '0));

  // issued lanes must come from the splitter mask of the previous cycle
  a_issue_needs_mask: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid & ~$past(lane_valid)) == '0);

endmodule

// File: rv_decode_stage.sv
`timescale 1ns/1ns
`include "rv_dec_cfg.svh"

module rv_decode_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  logic [`DEC_LANES*`XLEN-1:0]   in_instr,
  input  logic [`DEC_LANES-1:0]         in_lane_mask,
  output logic [`DEC_LANES-1:0]         out_valid,
  output logic [`DEC_LANES-1:0]         out_rd_valid,
  output logic [`DEC_LANES-1:0]         out_rs1_valid,
  output logic [`DEC_LANES-1:0]         out_rs2_valid,
  output rv_dec_pkg::mem_op_t           out_mem_op [`DEC_LANES],
  output rv_dec_pkg::cf_op_t            out_cf_op [`DEC_LANES],
  output rv_dec_pkg::csr_op_t           out_csr_op [`DEC_LANES],
  output rv_dec_pkg::alu_ctrl_t         out_alu_control [`DEC_LANES],
  output rv_dec_pkg::alu_a_sel_t        out_alu_a_src [`DEC_LANES],
  output rv_dec_pkg::alu_b_sel_t        out_alu_b_src [`DEC_LANES],
  output rv_dec_pkg::result_sel_t       out_result_src [`DEC_LANES],
  output logic [`DEC_LANES-1:0]         out_csr_bitmask_sel,
  output logic [`XLEN-1:0]              out_imm [`DEC_LANES],
  output logic                          out_trap_valid,
  output logic [`TRAP_LANE_W-1:0]       out_trap_lane,
  output rv_dec_pkg::trap_code_t        out_trap_mcause
);

  logic [`XLEN-1:0]        lane_instr [`DEC_LANES];
  logic [`DEC_LANES-1:0]   lane_valid;
  logic [`DEC_LANES-1:0]   dec_rd_valid;
  logic [`DEC_LANES-1:0]   dec_rs1_valid;
  logic [`DEC_LANES-1:0]   dec_rs2_valid;
  rv_dec_pkg::mem_op_t     dec_mem_op [`DEC_LANES];
  rv_dec_pkg::cf_op_t      dec_cf_op [`DEC_LANES];
  rv_dec_pkg::csr_op_t     dec_csr_op [`DEC_LANES];
  rv_dec_pkg::alu_ctrl_t   dec_alu_control [`DEC_LANES];
  rv_dec_pkg::alu_a_sel_t  dec_alu_a_src [`DEC_LANES];
  rv_dec_pkg::alu_b_sel_t  dec_alu_b_src [`DEC_LANES];
  rv_dec_pkg::result_sel_t dec_result_src [`DEC_LANES];
  logic [`DEC_LANES-1:0]   dec_csr_bitmask_sel;
  logic [`XLEN-1:0]        dec_imm [`DEC_LANES];
  logic [`DEC_LANES-1:0]   dec_trap_valid;
  rv_dec_pkg::trap_code_t  dec_trap_mcause [`DEC_LANES];

  fetch_bundle_split i_fetch_bundle_split (.*);

  for (genvar i = 0; i < `DEC_LANES; i++) begin : g_lane
    rv_dec_pkg::imm_ext_op_t imm_kind;

    decoder i_decoder (
      .instr           (lane_instr[i]),
      .rd_valid        (dec_rd_valid[i]),
      .rs1_valid       (dec_rs1_valid[i]),
      .rs2_valid       (dec_rs2_valid[i]),
      .mem_op          (dec_mem_op[i]),
      .cf_op           (dec_cf_op[i]),
      .csr_op          (dec_csr_op[i]),
      .alu_control     (dec_alu_control[i]),
      .imm_kind        (imm_kind),
      .alu_a_src       (dec_alu_a_src[i]),
      .alu_b_src       (dec_alu_b_src[i]),
      .pc_alu_src      (),  // consumed by the branch unit, outside this stage
      .result_src      (dec_result_src[i]),
      .csr_bitmask_sel (dec_csr_bitmask_sel[i]),
      .trap_valid      (dec_trap_valid[i]),
      .trap_mcause     (dec_trap_mcause[i])
    );

    imm_extender i_imm_extender (
      .instr    (lane_instr[i]),
      .imm_kind (imm_kind),
      .imm      (dec_imm[i])
    );
  end

  issue_collector i_issue_collector (.*);

endmodule

// File: tb_rv_ref.svh
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

typedef struct packed {
  logic                    rd_valid;
  logic                    rs1_valid;
  logic                    rs2_valid;
  rv_dec_pkg::mem_op_t     mem_op;
  rv_dec_pkg::cf_op_t      cf_op;
  rv_dec_pkg::csr_op_t     csr_op;
  rv_dec_pkg::alu_ctrl_t   alu_control;
  rv_dec_pkg::alu_a_sel_t  alu_a_src;
  rv_dec_pkg::alu_b_sel_t  alu_b_src;
  rv_dec_pkg::result_sel_t result_src;
  logic                    csr_bitmask_sel;
  logic [31:0]             imm;
  logic                    trap_valid;
  rv_dec_pkg::trap_code_t  trap_mcause;
} exp_lane_t;

// immediate layouts straight from the isa manual
function automatic logic [31:0] expected_imm(input logic [31:0] w,
                                              input rv_dec_pkg::imm_ext_op_t k);
  case (k)
    rv_dec_pkg::IMM_I_SHIFT: return {27'd0, w[24:20]};
    rv_dec_pkg::IMM_S:       return {{20{w[31]}}, w[31:25], w[11:7]};
    rv_dec_pkg::IMM_B:       return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    rv_dec_pkg::IMM_U:       return {w[31:12], 12'd0};
    rv_dec_pkg::IMM_J:       return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    rv_dec_pkg::IMM_CSR:     return {27'd0, w[19:15]};
    default:                 return {{20{w[31]}}, w[31:20]};
  endcase
endfunction

function automatic rv_dec_pkg::alu_ctrl_t arith_op(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? rv_dec_pkg::ALU_SUB : rv_dec_pkg::ALU_ADD;
    3'd1:    return rv_dec_pkg::ALU_SLL;
    3'd2:    return rv_dec_pkg::ALU_LT;
    3'd3:    return rv_dec_pkg::ALU_LTU;
    3'd4:    return rv_dec_pkg::ALU_XOR;
    3'd5:    return alt ? rv_dec_pkg::ALU_SRA : rv_dec_pkg::ALU_SRL;
    3'd6:    return rv_dec_pkg::ALU_OR;
    default: return rv_dec_pkg::ALU_AND;
  endcase
endfunction

function automatic exp_lane_t ref_decode(input logic [31:0] w);
  exp_lane_t               e;
  rv_dec_pkg::imm_ext_op_t k;
  logic [2:0]              f3;
  logic [6:0]              f7;
  logic                    rs1_zero;
  f3 = w[14:12];
  f7 = w[31:25];
  rs1_zero = (w[19:15] == 5'd0);
  k = rv_dec_pkg::IMM_I_ALU;
  e = '0;
  e.trap_mcause = rv_dec_pkg::TRAP_ILLEGAL;
  case (w[6:0])
    7'h03: begin
      e.rd_valid = 1'b1;
      e.rs1_valid = 1'b1;
      e.alu_b_src = rv_dec_pkg::ALU_B_IMM;
      e.result_src = rv_dec_pkg::RES_MEM;
      case (f3)
        3'd0: e.mem_op = rv_dec_pkg::MEM_LB;
        3'd1: e.mem_op = rv_dec_pkg::MEM_LH;
        3'd2: e.mem_op = rv_dec_pkg::MEM_LW;
        3'd4: e.mem_op = rv_dec_pkg::MEM_LBU;
        3'd5: e.mem_op = rv_dec_pkg::MEM_LHU;
        default: e.trap_valid = 1'b1;
      endcase
    end
    7'h23: begin
      e.rs1_valid = 1'b1;
      e.rs2_valid = 1'b1;
      e.alu_b_src = rv_dec_pkg::ALU_B_IMM;
      k = rv_dec_pkg::IMM_S;
      case (f3)
        3'd0: e.mem_op = rv_dec_pkg::MEM_SB;
        3'd1: e.mem_op = rv_dec_pkg::MEM_SH;
        3'd2: e.mem_op = rv_dec_pkg::MEM_SW;
        default: e.trap_valid = 1'b1;
      endcase
    end
    7'h33: begin
      e.trap_valid = !((f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5))));
      e.rd_valid = 1'b1;
      e.rs1_valid = 1'b1;
      e.rs2_valid = 1'b1;
      e.alu_control = arith_op(f3, f7 == 7'h20);
    end
    7'h13: begin
      if (f3 == 3'd1) e.trap_valid = (f7 != 7'h00);
      if (f3 == 3'd5) e.trap_valid = (f7 != 7'h00) && (f7 != 7'h20);
      e.rd_valid = 1'b1;
      e.rs1_valid = 1'b1;
      e.alu_b_src = rv_dec_pkg::ALU_B_IMM;
      e.alu_control = arith_op(f3, (f3 == 3'd5) && w[30]);  // addi never subtracts
      if ((f3 == 3'd1) || (f3 == 3'd5)) k = rv_dec_pkg::IMM_I_SHIFT;
    end
    7'h63: begin
      e.rs1_valid = 1'b1;
      e.rs2_valid = 1'b1;
      e.cf_op = rv_dec_pkg::CF_BRANCH;
      k = rv_dec_pkg::IMM_B;
      case (f3)
        3'd0: e.alu_control = rv_dec_pkg::ALU_SUB;
        3'd1: e.alu_control = rv_dec_pkg::ALU_NE;
        3'd4: e.alu_control = rv_dec_pkg::ALU_LT;
        3'd5: e.alu_control = rv_dec_pkg::ALU_GE;
        3'd6: e.alu_control = rv_dec_pkg::ALU_LTU;
        3'd7: e.alu_control = rv_dec_pkg::ALU_GEU;
        default: e.trap_valid = 1'b1;
      endcase
    end
    7'h6f: begin
      e.rd_valid = 1'b1;
      e.cf_op = rv_dec_pkg::CF_JUMP;
      e.result_src = rv_dec_pkg::RES_NEXT_PC;
      k = rv_dec_pkg::IMM_J;
    end
    7'h67: begin
      e.rd_valid = 1'b1;
      e.rs1_valid = 1'b1;
      e.alu_b_src = rv_dec_pkg::ALU_B_IMM;
      e.cf_op = rv_dec_pkg::CF_JALR;
      e.result_src = rv_dec_pkg::RES_NEXT_PC;
      e.trap_valid = (f3 != 3'd0);
    end
    7'h37, 7'h17: begin
      e.rd_valid = 1'b1;
      e.alu_a_src = w[5] ? rv_dec_pkg::ALU_A_ZERO : rv_dec_pkg::ALU_A_PC;  // lui vs auipc
      e.alu_b_src = rv_dec_pkg::ALU_B_IMM;
      k = rv_dec_pkg::IMM_U;
    end
    7'h73: begin
      if ((f3 == 3'd0) || (f3 == 3'd4)) begin
        e.trap_valid = 1'b1;
        if ((f3 == 3'd0) && (w[19:7] == 13'd0) && (w[31:20] == 12'h000)) begin
          e.trap_mcause = rv_dec_pkg::TRAP_ECALL_M;
        end
        if ((f3 == 3'd0) && (w[19:7] == 13'd0) && (w[31:20] == 12'h001)) begin
          e.trap_mcause = rv_dec_pkg::TRAP_BREAKPOINT;
        end
      end else begin
        e.rd_valid = 1'b1;
        e.rs1_valid = !f3[2];
        e.result_src = rv_dec_pkg::RES_CSR;
        e.csr_bitmask_sel = f3[2];
        if (f3[2]) k = rv_dec_pkg::IMM_CSR;
        if (f3[1:0] == 2'd1) e.csr_op = rv_dec_pkg::CSR_WRITE;
        if ((f3[1:0] == 2'd2) && !rs1_zero) e.csr_op = rv_dec_pkg::CSR_SET;
        if ((f3[1:0] == 2'd3) && !rs1_zero) e.csr_op = rv_dec_pkg::CSR_CLEAR;
      end
    end
    default: e.trap_valid = 1'b1;
  endcase
  e.imm = expected_imm(w, k);
  return e;
endfunction

`endif

// File: tb_rv_decode_stage.sv
`timescale 1ns/1ns
`include "rv_dec_cfg.svh"

module tb_rv_decode_stage;

  localparam int L = `DEC_LANES;
  localparam int W = `XLEN;
  localparam int TW = `TRAP_LANE_W;
  localparam int RST_CYCLES = 5;
  localparam int N_DIR = 62;
  localparam int N_RAND = 400;
  localparam int N_CYCLES = RST_CYCLES + N_DIR + 4 + N_RAND + 12;

  `include "tb_rv_ref.svh"

  typedef struct packed {
    int                     cyc;
    logic [L-1:0]           issue;
    logic                   trap;
    logic [TW-1:0]          tlane;
    rv_dec_pkg::trap_code_t cause;
    exp_lane_t [L-1:0]      lane;
  } exp_bundle_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    in_valid;
  logic [L*W-1:0]          in_instr;
  logic [L-1:0]            in_lane_mask;
  logic [L-1:0]            out_valid;
  logic [L-1:0]            out_rd_valid;
  logic [L-1:0]            out_rs1_valid;
  logic [L-1:0]            out_rs2_valid;
  rv_dec_pkg::mem_op_t     out_mem_op [L];
  rv_dec_pkg::cf_op_t      out_cf_op [L];
  rv_dec_pkg::csr_op_t     out_csr_op [L];
  rv_dec_pkg::alu_ctrl_t   out_alu_control [L];
  rv_dec_pkg::alu_a_sel_t  out_alu_a_src [L];
  rv_dec_pkg::alu_b_sel_t  out_alu_b_src [L];
  rv_dec_pkg::result_sel_t out_result_src [L];
  logic [L-1:0]            out_csr_bitmask_sel;
  logic [W-1:0]            out_imm [L];
  logic                    out_trap_valid;
  logic [TW-1:0]           out_trap_lane;
  rv_dec_pkg::trap_code_t  out_trap_mcause;

  int                      cyc = 0;
  int                      err_count = 0;
  logic [31:0]             seed;
  exp_bundle_t             exp_q [$];

  logic [6:0] legal_ops [10] = '{7'h03, 7'h23, 7'h33, 7'h13, 7'h63,
                                 7'h6f, 7'h67, 7'h37, 7'h17, 7'h73};

  logic [31:0] dir_words [N_DIR] = '{
    32'hffc30283, 32'hffc31283, 32'hffc32283, 32'hffc34283, 32'hffc35283,  // loads
    32'h00730423, 32'h00731423, 32'h00732423,
    32'h003100b3, 32'h403100b3, 32'h003110b3, 32'h003120b3, 32'h003130b3, 32'h003140b3,
    32'h003150b3, 32'h403150b3, 32'h003160b3, 32'h003170b3,
    32'hfff10093, 32'h00512093, 32'h00513093, 32'hfff14093, 32'h00516093, 32'h00517093,
    32'h40010093, 32'h00311093, 32'h00315093, 32'h40315093,
    32'hfe310ce3, 32'hfe311ce3, 32'hfe314ce3, 32'hfe315ce3, 32'hfe316ce3, 32'hfe317ce3,
    32'h123452b7, 32'h12345297, 32'h010000ef, 32'hffdff0ef, 32'h004100e7,
    32'h300312f3, 32'h300322f3, 32'h300332f3, 32'h300022f3, 32'h300352f3, 32'h300362f3,
    32'h300372f3, 32'h300072f3,
    32'h00000073, 32'h00100073, 32'h000000f3, 32'h00004073, 32'h10500073,  // system traps
    32'hffc33283, 32'h00733423, 32'hfe312ce3, 32'h004110e7, 32'h023100b3, 32'h403110b3,
    32'h40311093, 32'h0000000b, 32'hffffffff, 32'h00000000
  };

  rv_decode_stage i_rv_decode_stage (.*);

  always #4 clk = ~clk;  // 8 ns period

  always @(posedge clk) cyc <= cyc + 1;

  task automatic random_word(output logic [31:0] w);
    logic [31:0] sel;
    sel = $random(seed);
    w = $random(seed);
    if (sel[1:0] != 2'b00) w[6:0] = legal_ops[sel[5:2] % 4'd10];  // mostly real opcodes
  endtask

  task automatic drive_bundle(input logic [L*W-1:0] flat, input logic [L-1:0] mask);
    exp_bundle_t e;
    exp_lane_t   r;
    @(negedge clk);
    in_valid = 1'b1;
    in_instr = flat;
    in_lane_mask = mask;
    e = '0;
    e.cyc = cyc;
    e.cause = rv_dec_pkg::TRAP_ILLEGAL;
    for (int i = 0; i < L; i++) begin
      r = ref_decode(flat[i*W +: W]);
      e.lane[i] = r;
      if (mask[i] && !e.trap) begin
        if (r.trap_valid) begin
          e.trap = 1'b1;
          e.tlane = i[TW-1:0];
          e.cause = r.trap_mcause;
        end else begin
          e.issue[i] = 1'b1;
        end
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic drive_pair(input logic [31:0] w0, input logic [31:0] w1,
                            input logic [L-1:0] mask);
    logic [L*W-1:0] flat;
    for (int i = 0; i < L; i++) begin
      flat[i*W +: W] = (i == 0) ? w0 : ((i == 1) ? w1 : 32'h00000013);
    end
    drive_bundle(flat, mask);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
    in_lane_mask = '0;
  endtask

  task automatic check_field(input string name, input int lane,
                             input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      err_count++;
      $display("error %0t %s[%0d] got %h expected %h", $time, name, lane, got, want);
    end
  endtask

  // outputs only move on posedge, so the falling edge is a safe sample point
  always @(negedge clk) begin : compare
    exp_bundle_t e;
    if (!rst_n || exp_q.size() == 0 || exp_q[0].cyc + 2 != cyc) begin
      assert (out_valid == '0 && !out_trap_valid) else begin
        err_count++;
        $display("unexpected output at %0t with no bundle due: out_valid %b out_trap_valid %b",
                 $time, out_valid, out_trap_valid);
      end
    end else begin
      e = exp_q.pop_front();
      check_field("out_valid", 0, 32'(out_valid), 32'(e.issue));
      check_field("out_trap_valid", 0, 32'(out_trap_valid), 32'(e.trap));
      if (e.trap) begin
        check_field("out_trap_lane", 0, 32'(out_trap_lane), 32'(e.tlane));
        check_field("out_trap_mcause", 0, 32'(out_trap_mcause), 32'(e.cause));
      end
      for (int i = 0; i < L; i++) begin
        if (e.issue[i]) begin
          check_field("out_rd_valid", i, 32'(out_rd_valid[i]), 32'(e.lane[i].rd_valid));
          check_field("out_rs1_valid", i, 32'(out_rs1_valid[i]), 32'(e.lane[i].rs1_valid));
          check_field("out_rs2_valid", i, 32'(out_rs2_valid[i]), 32'(e.lane[i].rs2_valid));
          check_field("out_mem_op", i, 32'(out_mem_op[i]), 32'(e.lane[i].mem_op));
          check_field("out_cf_op", i, 32'(out_cf_op[i]), 32'(e.lane[i].cf_op));
          check_field("out_csr_op", i, 32'(out_csr_op[i]), 32'(e.lane[i].csr_op));
          check_field("out_alu_control", i, 32'(out_alu_control[i]),
                      32'(e.lane[i].alu_control));
          check_field("out_alu_a_src", i, 32'(out_alu_a_src[i]), 32'(e.lane[i].alu_a_src));
          check_field("out_alu_b_src", i, 32'(out_alu_b_src[i]), 32'(e.lane[i].alu_b_src));
          check_field("out_result_src", i, 32'(out_result_src[i]), 32'(e.lane[i].result_src));
          check_field("out_csr_bitmask_sel", i, 32'(out_csr_bitmask_sel[i]),
                      32'(e.lane[i].csr_bitmask_sel));
          check_field("out_imm", i, out_imm[i], e.lane[i].imm);
        end
      end
    end
  end

  initial begin : stimulus
    logic [L*W-1:0] flat;
    logic [31:0]    v;
    logic [31:0]    word;
    int             lane;
    seed = 32'h0e1fc96f;
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_lane_mask = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) idle_cycle();

    // one directed word per bundle, rotating lanes, other lanes masked off
    for (int k = 0; k < N_DIR; k++) begin
      lane = k % L;
      for (int i = 0; i < L; i++) begin
        random_word(word);
        flat[i*W +: W] = word;
      end
      flat[lane*W +: W] = dir_words[k];
      drive_bundle(flat, L'(1) << lane);
    end

    drive_pair(32'hffffffff, 32'h00100093, '1);     // lane 0 trap kills lane 1
    drive_pair(32'h00100093, 32'h00000073, '1);     // ecall in lane 1
    drive_pair(32'h00100093, 32'hffffffff, L'(1));  // trap masked off
    drive_pair(32'hffffffff, 32'h00100093, L'(2));

    for (int n = 0; n < N_RAND; n++) begin
      v = $random(seed);
      for (int i = 0; i < L; i++) begin
        random_word(word);
        flat[i*W +: W] = word;
      end
      if (v[1:0] != 2'b00) drive_bundle(flat, L'($random(seed)));
      else idle_cycle();
    end

    repeat (4) idle_cycle();
    $display("errors %0d", err_count);
    if (err_count == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

  initial begin : watchdog
    #((N_CYCLES + 20) * 8);
    $display("timeout after %0d cycles, errors %0d", cyc, err_count);
    $display("tests failed");
    $finish;
  end

endmodule

// File: build.f
+incdir+.
rv_dec_pkg.sv
fetch_bundle_split.sv
decoder.sv
imm_extender.sv
issue_collector.sv
rv_decode_stage.sv
tb_rv_decode_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_decode_stage
RTL_TOP   ?= rv_decode_stage
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  := tests failed
PASS_MSG  := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
